/* hw/axis_buf_pkg.sv */
`default_nettype none

package axis_buf_pkg;

   // build mode of a stream register slice
   typedef enum logic [1:0] {
      SLICE_FULL   = 2'd0, // two entries, registered ready
      SLICE_LIGHT  = 2'd1, // one entry, half rate
      SLICE_BYPASS = 2'd2  // plain wires
   } slice_mode_e;

   // AXI4-Lite bus geometry of the control block
   localparam int AXIL_ADDR_WIDTH = 4;
   localparam int AXIL_DATA_WIDTH = 32;

   // register map, byte addresses
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL   = 4'h0;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_STATUS = 4'h4;
   localparam logic [AXIL_ADDR_WIDTH-1:0] REG_COUNT  = 4'h8;

   // REG_CTRL fields
   localparam int CTRL_PAUSE_BIT = 0; // read/write
   localparam int CTRL_CLEAR_BIT = 1; // write only, self clearing

   // response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_EXOKAY = 2'b01;
   localparam logic [1:0] RESP_SLVERR = 2'b10;
   localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

/* hw/axis_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axis_if #(
   parameter int DATA_WIDTH = 32
);

   logic [DATA_WIDTH-1:0] tdata;
   logic                  tlast;
   logic                  tvalid;
   logic                  tready;

   // drives the beat, sees back-pressure
   modport source (
      output tdata,
      output tlast,
      output tvalid,
      input  tready
   );

   // takes the beat, drives back-pressure
   modport sink (
      input  tdata,
      input  tlast,
      input  tvalid,
      output tready
   );

endinterface

`default_nettype wire

/* hw/axis_reg_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice #(
   parameter int                        DATA_WIDTH = 32,
   parameter axis_buf_pkg::slice_mode_e MODE       = axis_buf_pkg::SLICE_FULL
) (
   input  logic ACLK,
   input  logic ARESET,
   axis_if.sink s,
   axis_if.source m
);

   import axis_buf_pkg::*;

   localparam int PW = DATA_WIDTH + 1; // tlast rides above tdata

   generate
      if (MODE == SLICE_FULL) begin : g_full
         typedef enum logic [1:0] {EMPTY, ONE, TWO} state_e;

         state_e        state_q;
         logic [PW-1:0] main_q;
         logic [PW-1:0] spare_q;
         logic          ready_q;
         logic          areset_d1;
         logic          accept;
         logic          load_main;

         assign accept = s.tvalid & ready_q;

         always_comb begin
            case (state_q)
               EMPTY:   load_main = accept;
               ONE:     load_main = accept & m.tready;
               TWO:     load_main = m.tready; // refill from spare
               default: load_main = 1'b0;
            endcase
         end

         always_ff @(posedge ACLK) begin
            areset_d1 <= ARESET;
         end

         always_ff @(posedge ACLK) begin
            if (load_main) begin
               main_q <= (state_q == TWO) ? spare_q : {s.tlast, s.tdata};
            end
            if (accept) begin
               spare_q <= {s.tlast, s.tdata};
            end
         end

         always_ff @(posedge ACLK) begin
            if (ARESET) begin
               state_q <= EMPTY;
               ready_q <= 1'b0;
            end else if (areset_d1) begin
               ready_q <= 1'b1; // one idle cycle after reset
            end else begin
               case (state_q)
                  EMPTY: begin
                     if (accept) begin
                        state_q <= ONE;
                     end
                  end
                  ONE: begin
                     if (accept && !m.tready) begin
                        state_q <= TWO;
                        ready_q <= 1'b0;
                     end else if (!accept && m.tready) begin
                        state_q <= EMPTY;
                     end
                  end
                  TWO: begin
                     if (m.tready) begin
                        state_q <= ONE;
                        ready_q <= 1'b1;
                     end
                  end
                  default: state_q <= EMPTY;
               endcase
            end
         end

         assign s.tready           = ready_q;
         assign m.tvalid           = (state_q != EMPTY);
         assign {m.tlast, m.tdata} = main_q;
      end else if (MODE == SLICE_LIGHT) begin : g_light
         logic [PW-1:0] hold_q;
         logic          ready_q;
         logic          valid_q;
         logic          areset_d1;

         always_ff @(posedge ACLK) begin
            areset_d1 <= ARESET;
         end

         // alternates between accepting and holding
         always_ff @(posedge ACLK) begin
            if (ARESET) begin
               ready_q <= 1'b0;
               valid_q <= 1'b0;
            end else if (areset_d1) begin
               ready_q <= 1'b1;
            end else if (valid_q && m.tready) begin
               ready_q <= 1'b1;
               valid_q <= 1'b0;
            end else if (s.tvalid && ready_q) begin
               ready_q <= 1'b0;
               valid_q <= 1'b1;
            end
         end

         always_ff @(posedge ACLK) begin
            if (s.tvalid && ready_q) begin
               hold_q <= {s.tlast, s.tdata};
            end
         end

         assign s.tready           = ready_q;
         assign m.tvalid           = valid_q;
         assign {m.tlast, m.tdata} = hold_q;
      end else begin : g_bypass
         assign m.tdata  = s.tdata;
         assign m.tlast  = s.tlast;
         assign m.tvalid = s.tvalid;
         assign s.tready = m.tready;
      end
   endgenerate

endmodule

`default_nettype wire

/* hw/axis_sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_sync_fifo #(
   parameter int DATA_WIDTH  = 32,
   parameter int LEVEL_WIDTH = 4
) (
   input  logic                 ACLK,
   input  logic                 ARESET,
   axis_if.sink                 s,
   axis_if.source               m,
   input  logic                 hold_i,
   output logic [LEVEL_WIDTH:0] level_o
);

   localparam int DEPTH = 1 << LEVEL_WIDTH;
   localparam int PW    = DATA_WIDTH + 1;

   logic [PW-1:0]        mem [DEPTH];
   logic [LEVEL_WIDTH:0] wr_ptr_q;
   logic [LEVEL_WIDTH:0] rd_ptr_q;
   logic [LEVEL_WIDTH:0] level;
   logic                 ready_q;
   logic                 offered_q;
   logic                 full;
   logic                 empty;
   logic                 push;
   logic                 pop;

   // pointers carry one extra wrap bit
   assign level = wr_ptr_q - rd_ptr_q;
   assign full  = level[LEVEL_WIDTH]; // only set at level == DEPTH
   assign empty = (level == '0);

   assign s.tready = ready_q & ~full;
   // a beat already on offer stays up through a hold
   assign m.tvalid = ~empty & (~hold_i | offered_q);
   assign {m.tlast, m.tdata} = mem[rd_ptr_q[LEVEL_WIDTH-1:0]];

   assign push = s.tvalid & s.tready;
   assign pop  = m.tvalid & m.tready;

   always_ff @(posedge ACLK) begin
      if (push) begin
         mem[wr_ptr_q[LEVEL_WIDTH-1:0]] <= {s.tlast, s.tdata};
      end
   end

   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         ready_q   <= 1'b0;
         offered_q <= 1'b0;
      end else begin
         ready_q   <= 1'b1; // low for one cycle after reset
         offered_q <= m.tvalid & ~m.tready;
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   assign level_o = level;

endmodule

`default_nettype wire

/* hw/axis_buf_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_buf_csr #(
   parameter int LEVEL_WIDTH = 4
) (
   input  logic                                     ACLK,
   input  logic                                     ARESET,
   input  logic [axis_buf_pkg::AXIL_ADDR_WIDTH-1:0] awaddr_i,
   input  logic                                     awvalid_i,
   output logic                                     awready_o,
   input  logic [axis_buf_pkg::AXIL_DATA_WIDTH-1:0] wdata_i,
   input  logic                                     wvalid_i,
   output logic                                     wready_o,
   output logic [1:0]                               bresp_o,
   output logic                                     bvalid_o,
   input  logic                                     bready_i,
   input  logic [axis_buf_pkg::AXIL_ADDR_WIDTH-1:0] araddr_i,
   input  logic                                     arvalid_i,
   output logic                                     arready_o,
   output logic [axis_buf_pkg::AXIL_DATA_WIDTH-1:0] rdata_o,
   output logic [1:0]                               rresp_o,
   output logic                                     rvalid_o,
   input  logic                                     rready_i,
   output logic                                     pause_o,
   input  logic [LEVEL_WIDTH:0]                     level_i,
   input  logic                                     out_beat_i
);

   import axis_buf_pkg::*;

   typedef enum logic {W_IDLE, W_RESP} wstate_e;

   wstate_e                    w_state_q;
   logic                       awready_q;
   logic                       wready_q;
   logic                       aw_got_q;
   logic                       w_got_q;
   logic [AXIL_ADDR_WIDTH-1:0] awaddr_q;
   logic [AXIL_DATA_WIDTH-1:0] wdata_q;
   logic [AXIL_ADDR_WIDTH-1:0] wr_addr;
   logic [AXIL_DATA_WIDTH-1:0] wr_data;
   logic                       aw_done;
   logic                       w_done;
   logic                       wr_fire;
   logic                       ctrl_wr;
   logic                       count_clr;
   logic                       pause_q;
   logic [31:0]                count_q;
   logic                       arready_q;
   logic                       rvalid_q;
   logic [AXIL_DATA_WIDTH-1:0] rdata_q;
   logic [AXIL_DATA_WIDTH-1:0] rd_word;

   // address and data may come in either order, or together
   assign aw_done = aw_got_q | (awvalid_i & awready_q);
   assign w_done  = w_got_q | (wvalid_i & wready_q);
   assign wr_addr = aw_got_q ? awaddr_q : awaddr_i;
   assign wr_data = w_got_q ? wdata_q : wdata_i;

   assign wr_fire   = (w_state_q == W_IDLE) & aw_done & w_done;
   assign ctrl_wr   = wr_fire & (wr_addr == REG_CTRL);
   assign count_clr = ctrl_wr & wr_data[CTRL_CLEAR_BIT];

   always_ff @(posedge ACLK) begin
      if (awvalid_i && awready_q) begin
         awaddr_q <= awaddr_i;
      end
      if (wvalid_i && wready_q) begin
         wdata_q <= wdata_i;
      end
   end

   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         w_state_q <= W_IDLE;
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         aw_got_q  <= 1'b0;
         w_got_q   <= 1'b0;
         pause_q   <= 1'b0;
      end else begin
         // single cycle ready pulses
         awready_q <= (w_state_q == W_IDLE) & ~wr_fire & awvalid_i & ~awready_q & ~aw_got_q;
         wready_q  <= (w_state_q == W_IDLE) & ~wr_fire & wvalid_i & ~wready_q & ~w_got_q;
         if (wr_fire) begin
            w_state_q <= W_RESP;
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
            if (ctrl_wr) begin
               pause_q <= wr_data[CTRL_PAUSE_BIT];
            end
         end else begin
            if (awvalid_i && awready_q) begin
               aw_got_q <= 1'b1;
            end
            if (wvalid_i && wready_q) begin
               w_got_q <= 1'b1;
            end
         end
         if (w_state_q == W_RESP && bready_i) begin
            w_state_q <= W_IDLE;
         end
      end
   end

   // beat counter, clear beats increment
   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         count_q <= '0;
      end else if (count_clr) begin
         count_q <= '0;
      end else if (out_beat_i) begin
         count_q <= count_q + 1'b1;
      end
   end

   always_comb begin
      case (araddr_i)
         REG_CTRL:   rd_word = {{(AXIL_DATA_WIDTH-1){1'b0}}, pause_q};
         REG_STATUS: rd_word = {{(AXIL_DATA_WIDTH-LEVEL_WIDTH-1){1'b0}}, level_i};
         REG_COUNT:  rd_word = count_q;
         default:    rd_word = '0; // unmapped
      endcase
   end

   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
      end else begin
         arready_q <= arvalid_i & ~arready_q & ~rvalid_q;
         if (arvalid_i && arready_q) begin
            rvalid_q <= 1'b1;
         end else if (rready_i) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge ACLK) begin
      if (arvalid_i && arready_q) begin
         rdata_q <= rd_word;
      end
   end

   assign awready_o = awready_q;
   assign wready_o  = wready_q;
   assign bvalid_o  = (w_state_q == W_RESP);
   assign bresp_o   = RESP_OKAY;
   assign arready_o = arready_q;
   assign rvalid_o  = rvalid_q;
   assign rdata_o   = rdata_q;
   assign rresp_o   = RESP_OKAY;
   assign pause_o   = pause_q;

endmodule

`default_nettype wire

/* hw/axis_buf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_buf_top #(
   parameter int                        DATA_WIDTH     = 32,
   parameter int                        LEVEL_WIDTH    = 4,
   parameter axis_buf_pkg::slice_mode_e IN_SLICE_MODE  = axis_buf_pkg::SLICE_FULL,
   parameter axis_buf_pkg::slice_mode_e OUT_SLICE_MODE = axis_buf_pkg::SLICE_FULL
) (
   input  logic                                     ACLK,
   input  logic                                     ARESET,
   input  logic [DATA_WIDTH-1:0]                    s_axis_tdata_i,
   input  logic                                     s_axis_tlast_i,
   input  logic                                     s_axis_tvalid_i,
   output logic                                     s_axis_tready_o,
   output logic [DATA_WIDTH-1:0]                    m_axis_tdata_o,
   output logic                                     m_axis_tlast_o,
   output logic                                     m_axis_tvalid_o,
   input  logic                                     m_axis_tready_i,
   input  logic [axis_buf_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr_i,
   input  logic                                     s_axil_awvalid_i,
   output logic                                     s_axil_awready_o,
   input  logic [axis_buf_pkg::AXIL_DATA_WIDTH-1:0] s_axil_wdata_i,
   input  logic                                     s_axil_wvalid_i,
   output logic                                     s_axil_wready_o,
   output logic [1:0]                               s_axil_bresp_o,
   output logic                                     s_axil_bvalid_o,
   input  logic                                     s_axil_bready_i,
   input  logic [axis_buf_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr_i,
   input  logic                                     s_axil_arvalid_i,
   output logic                                     s_axil_arready_o,
   output logic [axis_buf_pkg::AXIL_DATA_WIDTH-1:0] s_axil_rdata_o,
   output logic [1:0]                               s_axil_rresp_o,
   output logic                                     s_axil_rvalid_o,
   input  logic                                     s_axil_rready_i
);

   logic                 pause;
   logic [LEVEL_WIDTH:0] level;

   axis_if #(.DATA_WIDTH(DATA_WIDTH)) axis_in ();
   axis_if #(.DATA_WIDTH(DATA_WIDTH)) in_to_fifo ();
   axis_if #(.DATA_WIDTH(DATA_WIDTH)) fifo_to_out ();
   axis_if #(.DATA_WIDTH(DATA_WIDTH)) axis_out ();

   // plain ports onto the internal links
   assign axis_in.tdata   = s_axis_tdata_i;
   assign axis_in.tlast   = s_axis_tlast_i;
   assign axis_in.tvalid  = s_axis_tvalid_i;
   assign s_axis_tready_o = axis_in.tready;

   assign m_axis_tdata_o  = axis_out.tdata;
   assign m_axis_tlast_o  = axis_out.tlast;
   assign m_axis_tvalid_o = axis_out.tvalid;
   assign axis_out.tready = m_axis_tready_i;

   axis_reg_slice #(.DATA_WIDTH(DATA_WIDTH), .MODE(IN_SLICE_MODE)) in_slice (
      .ACLK(ACLK), .ARESET(ARESET), .s(axis_in), .m(in_to_fifo)
   );

   axis_sync_fifo #(.DATA_WIDTH(DATA_WIDTH), .LEVEL_WIDTH(LEVEL_WIDTH)) fifo (
      .ACLK(ACLK), .ARESET(ARESET), .s(in_to_fifo), .m(fifo_to_out),
      .hold_i(pause), .level_o(level)
   );

   axis_reg_slice #(.DATA_WIDTH(DATA_WIDTH), .MODE(OUT_SLICE_MODE)) out_slice (
      .ACLK(ACLK), .ARESET(ARESET), .s(fifo_to_out), .m(axis_out)
   );

   axis_buf_csr #(.LEVEL_WIDTH(LEVEL_WIDTH)) csr (
      .ACLK(ACLK), .ARESET(ARESET),
      .awaddr_i(s_axil_awaddr_i), .awvalid_i(s_axil_awvalid_i), .awready_o(s_axil_awready_o),
      .wdata_i(s_axil_wdata_i), .wvalid_i(s_axil_wvalid_i), .wready_o(s_axil_wready_o),
      .bresp_o(s_axil_bresp_o), .bvalid_o(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
      .araddr_i(s_axil_araddr_i), .arvalid_i(s_axil_arvalid_i), .arready_o(s_axil_arready_o),
      .rdata_o(s_axil_rdata_o), .rresp_o(s_axil_rresp_o), .rvalid_o(s_axil_rvalid_o),
      .rready_i(s_axil_rready_i),
      .pause_o(pause), .level_i(level),
      .out_beat_i(m_axis_tvalid_o & m_axis_tready_i) // output handshakes
   );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 50,
   parameter int RESET_CYCLES   = 10
) (
   output logic aclk_o,
   output logic areset_o
);

   initial begin
      aclk_o = 1'b0;
      forever #(HALF_PERIOD_NS) aclk_o = ~aclk_o;
   end

   initial begin
      areset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge aclk_o);
      #1 areset_o = 1'b0; // released just after the edge, like all other inputs
   end

endmodule

`default_nettype wire

/* bench/axis_buf_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_buf_checker #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  ACLK,
   input  logic                  ARESET,
   input  logic [DATA_WIDTH-1:0] s_tdata_i,
   input  logic                  s_tlast_i,
   input  logic                  s_tvalid_i,
   input  logic                  s_tready_i,
   input  logic [DATA_WIDTH-1:0] m_tdata_i,
   input  logic                  m_tlast_i,
   input  logic                  m_tvalid_i,
   input  logic                  m_tready_i,
   input  logic                  quiet_i,
   output int                    data_errors_o,
   output int                    last_errors_o,
   output int                    other_errors_o,
   output int                    beat_count_o,
   output int                    pending_o
);

   logic [DATA_WIDTH:0] expected_q [$]; // {tlast, tdata} per accepted input beat
   logic [DATA_WIDTH:0] head;
   int                  data_errors = 0;
   int                  last_errors = 0;
   int                  other_errors = 0;
   int                  beat_count = 0;

   // sampled at the falling edge where values are stable
   always @(negedge ACLK) begin
      if (ARESET) begin
         expected_q.delete();
      end else begin
         if (s_tvalid_i && s_tready_i) begin
            expected_q.push_back({s_tlast_i, s_tdata_i});
         end
         if (m_tvalid_i && quiet_i) begin
            $display("Error at %0t: output tvalid is high while the FIFO is paused", $time);
            other_errors++;
         end
         if (m_tvalid_i && m_tready_i) begin
            beat_count++;
            if (expected_q.size() == 0) begin
               $display("Error at %0t: output beat with no matching input beat", $time);
               other_errors++;
            end else begin
               head = expected_q.pop_front();
               if (m_tdata_i !== head[DATA_WIDTH-1:0]) begin
                  $display("Mismatch at %0t: m_axis_tdata_o expected %h, got %h",
                           $time, head[DATA_WIDTH-1:0], m_tdata_i);
                  data_errors++;
               end
               if (m_tlast_i !== head[DATA_WIDTH]) begin
                  $display("Mismatch at %0t: m_axis_tlast_o expected %b, got %b",
                           $time, head[DATA_WIDTH], m_tlast_i);
                  last_errors++;
               end
            end
         end
      end
   end

   assign data_errors_o  = data_errors;
   assign last_errors_o  = last_errors;
   assign other_errors_o = other_errors;
   assign beat_count_o   = beat_count;
   assign pending_o      = expected_q.size();

endmodule

`default_nettype wire

/* bench/axis_buf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_buf_tb;

   import axis_buf_pkg::*;

   localparam int          DATA_WIDTH  = 32;
   localparam int          LEVEL_WIDTH = 4;
   localparam logic [31:0] SEED        = 32'h05475540;
   localparam int          AXIL_WAIT   = 100;  // cycles per bus handshake
   localparam int          BEAT_WAIT   = 200;
   localparam int          DRAIN_WAIT  = 4000;

   logic                  aclk;
   logic                  areset;
   logic [DATA_WIDTH-1:0] s_axis_tdata;
   logic                  s_axis_tlast;
   logic                  s_axis_tvalid;
   logic                  s_axis_tready;
   logic [DATA_WIDTH-1:0] m_axis_tdata;
   logic                  m_axis_tlast;
   logic                  m_axis_tvalid;
   logic                  m_axis_tready;
   logic [3:0]            s_axil_awaddr;
   logic                  s_axil_awvalid;
   logic                  s_axil_awready;
   logic [31:0]           s_axil_wdata;
   logic                  s_axil_wvalid;
   logic                  s_axil_wready;
   logic [1:0]            s_axil_bresp;
   logic                  s_axil_bvalid;
   logic                  s_axil_bready;
   logic [3:0]            s_axil_araddr;
   logic                  s_axil_arvalid;
   logic                  s_axil_arready;
   logic [31:0]           s_axil_rdata;
   logic [1:0]            s_axil_rresp;
   logic                  s_axil_rvalid;
   logic                  s_axil_rready;
   logic                  quiet;
   logic                  random_ready;
   int                    data_errors;
   int                    last_errors;
   int                    other_errors;
   int                    beat_count;
   int                    pending;
   int                    tb_errors = 0;
   int                    tests_passed = 0;
   int                    tests_failed = 0;

   tb_clock_gen clk_gen (
      .aclk_o(aclk),
      .areset_o(areset)
   );

   axis_buf_top #(
      .DATA_WIDTH(DATA_WIDTH),
      .LEVEL_WIDTH(LEVEL_WIDTH),
      .IN_SLICE_MODE(SLICE_FULL),
      .OUT_SLICE_MODE(SLICE_FULL)
   ) axis_buf_top_inst (
      .ACLK(aclk), .ARESET(areset),
      .s_axis_tdata_i(s_axis_tdata), .s_axis_tlast_i(s_axis_tlast),
      .s_axis_tvalid_i(s_axis_tvalid), .s_axis_tready_o(s_axis_tready),
      .m_axis_tdata_o(m_axis_tdata), .m_axis_tlast_o(m_axis_tlast),
      .m_axis_tvalid_o(m_axis_tvalid), .m_axis_tready_i(m_axis_tready),
      .s_axil_awaddr_i(s_axil_awaddr), .s_axil_awvalid_i(s_axil_awvalid),
      .s_axil_awready_o(s_axil_awready), .s_axil_wdata_i(s_axil_wdata),
      .s_axil_wvalid_i(s_axil_wvalid), .s_axil_wready_o(s_axil_wready),
      .s_axil_bresp_o(s_axil_bresp), .s_axil_bvalid_o(s_axil_bvalid),
      .s_axil_bready_i(s_axil_bready), .s_axil_araddr_i(s_axil_araddr),
      .s_axil_arvalid_i(s_axil_arvalid), .s_axil_arready_o(s_axil_arready),
      .s_axil_rdata_o(s_axil_rdata), .s_axil_rresp_o(s_axil_rresp),
      .s_axil_rvalid_o(s_axil_rvalid), .s_axil_rready_i(s_axil_rready)
   );

   axis_buf_checker #(.DATA_WIDTH(DATA_WIDTH)) stream_check (
      .ACLK(aclk), .ARESET(areset),
      .s_tdata_i(s_axis_tdata), .s_tlast_i(s_axis_tlast),
      .s_tvalid_i(s_axis_tvalid), .s_tready_i(s_axis_tready),
      .m_tdata_i(m_axis_tdata), .m_tlast_i(m_axis_tlast),
      .m_tvalid_i(m_axis_tvalid), .m_tready_i(m_axis_tready),
      .quiet_i(quiet),
      .data_errors_o(data_errors), .last_errors_o(last_errors),
      .other_errors_o(other_errors), .beat_count_o(beat_count), .pending_o(pending)
   );

   // random output back-pressure on about one cycle in four
   always @(posedge aclk) begin
      #1;
      if (random_ready) begin
         m_axis_tready = ($urandom_range(3) != 0);
      end else begin
         m_axis_tready = 1'b1;
      end
   end

   function automatic int error_total();
      return tb_errors + data_errors + last_errors + other_errors;
   endfunction

   task automatic abort_run(input string reason);
      $display("Error at %0t: %s", $time, reason);
      $display(">>> FAIL");
      $finish;
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
         tb_errors++;
      end
   endtask

   task automatic report_test(input string name, input bit ok);
      if (ok) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed", name);
      end
   endtask

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
      int         waited;
      logic       aw_seen;
      logic       w_seen;
      logic       b_seen;
      logic [1:0] resp;
      s_axil_awaddr  = addr;
      s_axil_awvalid = 1'b1;
      s_axil_wdata   = data;
      s_axil_wvalid  = 1'b1;
      waited = 0;
      while (s_axil_awvalid || s_axil_wvalid) begin
         @(negedge aclk);
         aw_seen = s_axil_awvalid && s_axil_awready;
         w_seen  = s_axil_wvalid && s_axil_wready;
         @(posedge aclk);
         #1;
         if (aw_seen) begin
            s_axil_awvalid = 1'b0;
         end
         if (w_seen) begin
            s_axil_wvalid = 1'b0;
         end
         waited++;
         if ((s_axil_awvalid || s_axil_wvalid) && waited > AXIL_WAIT) begin
            abort_run("AXI4-Lite write address or data was never accepted");
         end
      end
      s_axil_bready = 1'b1;
      b_seen = 1'b0;
      waited = 0;
      while (!b_seen) begin
         @(negedge aclk);
         b_seen = s_axil_bvalid;
         resp   = s_axil_bresp;
         @(posedge aclk);
         #1;
         waited++;
         if (!b_seen && waited > AXIL_WAIT) begin
            abort_run("AXI4-Lite write response never arrived");
         end
      end
      s_axil_bready = 1'b0;
      compare_value("s_axil_bresp_o", resp, RESP_OKAY);
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
      int         waited;
      logic       ar_seen;
      logic       r_seen;
      logic [1:0] resp;
      s_axil_araddr  = addr;
      s_axil_arvalid = 1'b1;
      ar_seen = 1'b0;
      waited = 0;
      while (!ar_seen) begin
         @(negedge aclk);
         ar_seen = s_axil_arready;
         @(posedge aclk);
         #1;
         waited++;
         if (!ar_seen && waited > AXIL_WAIT) begin
            abort_run("AXI4-Lite read address was never accepted");
         end
      end
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b1;
      r_seen = 1'b0;
      waited = 0;
      while (!r_seen) begin
         @(negedge aclk);
         r_seen = s_axil_rvalid;
         data   = s_axil_rdata;
         resp   = s_axil_rresp;
         @(posedge aclk);
         #1;
         waited++;
         if (!r_seen && waited > AXIL_WAIT) begin
            abort_run("AXI4-Lite read data never arrived");
         end
      end
      s_axil_rready = 1'b0;
      compare_value("s_axil_rresp_o", resp, RESP_OKAY);
   endtask

   task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
      int   waited;
      logic accepted;
      s_axis_tdata  = data;
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      accepted = 1'b0;
      waited = 0;
      while (!accepted) begin
         @(negedge aclk);
         accepted = s_axis_tready;
         @(posedge aclk);
         #1;
         waited++;
         if (!accepted && waited > BEAT_WAIT) begin
            abort_run("input beat was never accepted");
         end
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_stream(input int beats);
      for (int i = 0; i < beats; i++) begin
         send_beat($urandom, ($urandom_range(7) == 0));
         repeat ($urandom_range(3)) begin // idle gap
            @(posedge aclk);
            #1;
         end
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (pending != 0) begin
         @(posedge aclk);
         #1;
         waited++;
         if (pending != 0 && waited > DRAIN_WAIT) begin
            abort_run("beats stuck inside the DUT");
         end
      end
   endtask

   task automatic check_reset();
      int waited;
      waited = 0;
      @(negedge aclk);
      while (areset) begin
         @(negedge aclk);
         waited++;
         if (areset && waited > 20) begin
            abort_run("reset was never released");
         end
      end
      compare_value("s_axis_tready_o", s_axis_tready, 1'b0);
      compare_value("m_axis_tvalid_o", m_axis_tvalid, 1'b0);
      compare_value("s_axil_bvalid_o", s_axil_bvalid, 1'b0);
      compare_value("s_axil_rvalid_o", s_axil_rvalid, 1'b0);
      waited = 0;
      while (!s_axis_tready) begin
         @(negedge aclk);
         waited++;
         if (!s_axis_tready && waited >= 5) begin
            abort_run("s_axis_tready_o stayed low after reset");
         end
      end
      @(posedge aclk);
      #1;
   endtask

   initial begin
      int          errs;
      int          last_errs;
      int          beats_before;
      logic [31:0] rd;
      void'($urandom(SEED));
      $timeformat(-9, 0, " ns", 0);
      s_axis_tdata   = '0;
      s_axis_tlast   = 1'b0;
      s_axis_tvalid  = 1'b0;
      m_axis_tready  = 1'b0;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      quiet          = 1'b0;
      random_ready   = 1'b0;

      errs = error_total();
      check_reset();
      report_test("reset state", error_total() == errs);

      errs = error_total() - last_errors;
      last_errs = last_errors;
      beats_before = beat_count;
      random_ready = 1'b1;
      send_stream(500);
      wait_drained();
      compare_value("output beat count", beat_count - beats_before, 500);
      report_test("stream order and data", error_total() - last_errors == errs);
      report_test("tlast", last_errors == last_errs);

      errs = error_total();
      beats_before = beat_count;
      axil_write(REG_CTRL, 32'h1);
      quiet = 1'b1; // output must stay idle while paused
      send_stream(8);
      repeat (50) @(posedge aclk);
      #1;
      axil_read(REG_STATUS, rd);
      compare_value("REG_STATUS", rd, 8);
      quiet = 1'b0;
      axil_write(REG_CTRL, 32'h0);
      wait_drained();
      compare_value("output beat count", beat_count - beats_before, 8);
      report_test("pause and level", error_total() == errs);

      errs = error_total();
      axil_read(REG_COUNT, rd);
      compare_value("REG_COUNT", rd, beat_count);
      axil_write(REG_CTRL, 32'h3); // pause and clear the counter
      axil_read(REG_COUNT, rd);
      compare_value("REG_COUNT", rd, 0);
      report_test("beat counter", error_total() == errs);

      errs = error_total();
      axil_read(REG_CTRL, rd);
      compare_value("REG_CTRL", rd, 32'h1);
      axil_read(4'hC, rd);
      compare_value("unmapped register", rd, 0);
      axil_write(REG_CTRL, 32'h0);
      axil_read(REG_CTRL, rd);
      compare_value("REG_CTRL", rd, 32'h0);
      report_test("register access", error_total() == errs);

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
hw/axis_buf_pkg.sv
hw/axis_if.sv
hw/axis_reg_slice.sv
hw/axis_sync_fifo.sv
hw/axis_buf_csr.sv
hw/axis_buf_top.sv
bench/tb_clock_gen.sv
bench/axis_buf_checker.sv
bench/axis_buf_tb.sv

/* Makefile */
# Verilator build and run for the AXI-Stream buffer testbench

VERILATOR ?= verilator
TOP       ?= axis_buf_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
